//--- Makefile
VERILATOR ?= verilator
TOP ?= tb
FILELIST ?= tb.f
FLAGS ?= --binary --timing --assert -j 0
OBJDIR ?= obj_dir
LOG ?= sim.log
FAIL_MSG = sim failed
PASS_MSG = sim passed

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) --Mdir $(OBJDIR) -f $(FILELIST)

run: compile
	-./$(OBJDIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "Simulation FAILED"; exit 1; fi
	@grep -q "$(PASS_MSG)" $(LOG) || (echo "Simulation ended without passing"; exit 1)

clean:
	rm -rf $(OBJDIR) $(LOG)

//--- asciiFieldDecoder.sv
// Character front end that de-ASCIIizes load file fields and pushes the words of C lines
`include "ramLoad_macros.svh"

module asciiFieldDecoder import loadFilePkg::*; (
  input logic clk,
  input logic rst,
  input logic charStrobe,
  input asciiChar_t charIn,
  output logic formatError,
  wordFifoIf.writer fifo
);

  // Record type characters
  localparam asciiChar_t recCram = 7'h43;
  localparam asciiChar_t recDram = 7'h44;
  localparam asciiChar_t recZero = 7'h5a;
  localparam asciiChar_t recComment = 7'h3b;

  // Where the next character falls within its line
  typedef enum logic [1:0] {
    atType,
    atSpace,
    inFields
  } linePos_t;

  linePos_t linePos;
  logic isCLine;
  loadWord_t field;
  logic [`FIELD_BITS-1:0] group;
  logic isTerminator;
  logic isNewline;
  logic knownType;
  logic push;
  fieldEntry_t pushEntry;

  // 100..175 lose their 100 bit and all others pass as they are
  // Only the low six bits count, and those are the same either way
  function automatic logic [`FIELD_BITS-1:0] deAscii(input asciiChar_t ch);
    return ch[`FIELD_BITS-1:0];
  endfunction

  always_comb group = deAscii(charIn);

  assign isNewline = charIn == `CH_NEWLINE;
  assign isTerminator = isNewline || charIn == `CH_COMMA;
  assign knownType = charIn inside {recCram, recDram, recZero, recComment};

  ////////////////////////////////////////////////////////////////////////////
  // Line tracking and field accumulation
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (rst) begin
      linePos <= atType;
      isCLine <= 1'b0;
      field <= '0;
      push <= 1'b0;
      formatError <= 1'b0;
    end else begin
      push <= 1'b0;
      formatError <= 1'b0;
      if (charStrobe) begin
        case (linePos)
          atType: begin
            // Empty lines are passed over
            if (!isNewline) begin
              isCLine <= charIn == recCram;
              formatError <= !knownType;
              field <= '0;
              linePos <= atSpace;
            end
          end
          atSpace: linePos <= isNewline ? atType : inFields;
          default: begin
            if (isTerminator) begin
              // D, Z and comment lines are only walked through
              push <= isCLine;
              field <= '0;
              if (isNewline) linePos <= atType;
            end else begin
              // Shift in the next group, MS group arrives first
              field <= {field[`LOAD_WORD_BITS-`FIELD_BITS-1:0], group};
            end
          end
        endcase
      end
    end
  end

  // Entry is captured with the terminator, valid while push is high
  always_ff @(posedge clk) begin
    if (charStrobe && linePos == inFields && isTerminator) begin
      pushEntry.word <= field;
      pushEntry.lastInLine <= isNewline;
    end
  end

  assign fifo.push = push;
  assign fifo.pushEntry = pushEntry;

endmodule

//--- cramPkg.sv
// Address and word types of the KL10 control RAM
`include "ramLoad_macros.svh"

package cramPkg;

  // Control RAM location
  typedef logic [`CRAM_ADR_BITS-1:0] cramAdr_t;

  // One control RAM word
  // Numbered from the left as in the KL10 prints, bit 0 is the MSB
  // Bits 80 to 85 hold the CALL and DISP special field
  typedef logic [0:`CRAM_WORD_BITS-1] cramWord_t;

  // Bit ranges filled by the six data words of a C record
  // Slot 0 -> 64..79
  // Slot 1 -> 48..63
  // Slot 2 -> 32..47
  // Slot 3 -> 16..31
  // Slot 4 -> 0..15
  // Slot 5 -> 80..85 from the low six bits

endpackage

//--- cramRecordAssembler.sv
// C record consumer that resolves addresses, checks the line sum and builds CRAM words
`include "ramLoad_macros.svh"

module cramRecordAssembler import loadFilePkg::*, cramPkg::*; (
  input logic clk,
  input logic rst,
  wordFifoIf.reader fifo,
  output logic cramWrite,
  output cramAdr_t cramAdr,
  output cramWord_t cramData,
  output logic cksumError
);

  // Field index within a line, saturates on data
  localparam logic [1:0] fieldWc = 2'd0;
  localparam logic [1:0] fieldAdr = 2'd1;
  localparam logic [1:0] fieldData = 2'd2;
  localparam logic [2:0] lastSlot = 3'(`WORDS_PER_CRAM - 1);

  fieldEntry_t entry;
  logic take;
  logic isData;
  loadWord_t sumNext;
  logic [1:0] fieldIdx;
  logic [2:0] slot;
  loadWord_t wc;
  loadWord_t sum;
  cramAdr_t adr;
  logic endMarker;

  // Drain every cycle, nothing ever holds the buffer back
  assign take = fifo.notEmpty;
  assign fifo.pop = take;
  assign entry = fifo.popEntry;

  // Checksum is the last field, so the full sum lands on zero
  assign sumNext = sum + entry.word;
  assign isData = take && !entry.lastInLine && fieldIdx == fieldData;

  ////////////////////////////////////////////////////////////////////////////
  // Field sequencing, address and checksum
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (rst) begin
      fieldIdx <= fieldWc;
      slot <= '0;
      sum <= '0;
      adr <= '0;
      endMarker <= 1'b0;
      cramWrite <= 1'b0;
      cksumError <= 1'b0;
    end else begin
      cramWrite <= 1'b0;
      cksumError <= 1'b0;
      if (take) begin
        if (entry.lastInLine) begin
          cksumError <= sumNext != '0;
          sum <= '0;
          fieldIdx <= fieldWc;
          slot <= '0;
          // adr already points past the last word written
          if (endMarker) adr <= '0;
          endMarker <= 1'b0;
        end else begin
          sum <= sumNext;
          case (fieldIdx)
            fieldWc: fieldIdx <= fieldAdr;
            fieldAdr: begin
              fieldIdx <= fieldData;
              endMarker <= wc == '0 && entry.word == '0;
              // Zero ADR continues at the remembered address
              if (entry.word != '0) adr <= entry.word[`CRAM_ADR_BITS-1:0];
            end
            default: begin
              if (slot == lastSlot) begin
                slot <= '0;
                cramWrite <= 1'b1;
                adr <= adr + 1'b1;
              end else begin
                slot <= slot + 1'b1;
              end
            end
          endcase
        end
      end
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Word count and CRAM word assembly
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (take && !entry.lastInLine && fieldIdx == fieldWc) wc <= entry.word;
    if (isData) begin
      case (slot)
        3'd0: cramData[64:79] <= entry.word;
        3'd1: cramData[48:63] <= entry.word;
        3'd2: cramData[32:47] <= entry.word;
        3'd3: cramData[16:31] <= entry.word;
        3'd4: cramData[0:15] <= entry.word;
        // CALL and DISP special field
        default: cramData[80:85] <= entry.word[`FIELD_BITS-1:0];
      endcase
      // Address goes out together with the completed word
      if (slot == lastSlot) cramAdr <= adr;
    end
  end

endmodule

//--- loadFilePkg.sv
// Types for the character stream and 16-bit words of the microcode load file
`include "ramLoad_macros.svh"

package loadFilePkg;

  ////////////////////////////////////////////////////////////////////////////
  // Raw stream
  ////////////////////////////////////////////////////////////////////////////

  // One 7-bit character of the file
  typedef logic [`CHAR_BITS-1:0] asciiChar_t;

  // One decoded file word, most significant group first
  typedef logic [`LOAD_WORD_BITS-1:0] loadWord_t;

  ////////////////////////////////////////////////////////////////////////////
  // Buffer payload
  ////////////////////////////////////////////////////////////////////////////

  // Word plus end of line marker, 17 bits
  typedef struct packed {
    loadWord_t word;
    logic lastInLine;
  } fieldEntry_t;

endpackage

//--- ramLoad_macros.svh
// Load file loader widths and character constants shared by all blocks
`ifndef RAMLOAD_MACROS_SVH
`define RAMLOAD_MACROS_SVH

// Character stream
`define CHAR_BITS 7
`define FIELD_BITS 6

// Load file words
`define LOAD_WORD_BITS 16

// Control RAM geometry
`define CRAM_ADR_BITS 11
`define CRAM_WORD_BITS 86
`define WORDS_PER_CRAM 6

// Word buffer between decoder and assembler
`define FIFO_DEPTH 4

// Line and field terminators
`define CH_NEWLINE 7'o012
`define CH_COMMA 7'h2c

`endif

//--- ramLoader.sv
// KL10 microcode load file loader top, characters in and CRAM write strobes out
module ramLoader import loadFilePkg::*, cramPkg::*; (
  input logic clk,
  input logic rst,
  input logic charStrobe,
  input asciiChar_t charIn,
  output logic cramWrite,
  output cramAdr_t cramAdr,
  output cramWord_t cramData,
  output logic cksumError,
  output logic formatError
);

  // Decoder to buffer
  wordFifoIf #(.entryT(fieldEntry_t)) prodIf ();

  // Buffer to assembler
  wordFifoIf #(.entryT(fieldEntry_t)) consIf ();

  // Characters to 16-bit words, one push per terminator
  asciiFieldDecoder decoder (
    .clk (clk),
    .rst (rst),
    .charStrobe (charStrobe),
    .charIn (charIn),
    .formatError (formatError),
    .fifo (prodIf.writer)
  );

  // Decouples the two sides by one cycle
  wordFifo #(.entryT(fieldEntry_t)) wordBuffer (
    .clk (clk),
    .rst (rst),
    .wr (prodIf.bufferIn),
    .rd (consIf.bufferOut)
  );

  // Words to CRAM writes and checksum result
  cramRecordAssembler assembler (
    .clk (clk),
    .rst (rst),
    .fifo (consIf.reader),
    .cramWrite (cramWrite),
    .cramAdr (cramAdr),
    .cramData (cramData),
    .cksumError (cksumError)
  );

endmodule

//--- ramLoader_asserts.sv
// Bound checks on loader output pulses, reset behavior and word buffer occupancy
`include "ramLoad_macros.svh"

module ramLoaderAsserts (
  input logic clk,
  input logic rst,
  input logic cramWrite,
  input logic cksumError,
  input logic formatError,
  input logic [$clog2(`FIFO_DEPTH + 1)-1:0] bufCount
);

  timeunit 1ns;
  timeprecision 100ps;

  // Number of failed properties so far
  int failCount = 0;

  // Every output strobe is a single cycle
  cramWriteSingle: assert property (@(posedge clk) disable iff (rst) cramWrite |=> !cramWrite)
    else begin
      $error("cramWrite held high for two cycles");
      failCount++;
    end
  cksumSingle: assert property (@(posedge clk) disable iff (rst) cksumError |=> !cksumError)
    else begin
      $error("cksumError held high for two cycles");
      failCount++;
    end
  formatSingle: assert property (@(posedge clk) disable iff (rst) formatError |=> !formatError)
    else begin
      $error("formatError held high for two cycles");
      failCount++;
    end

  // Synchronous reset clears the strobes one edge later
  quietInReset: assert property (@(posedge clk) rst |=> !cramWrite && !cksumError)
    else begin
      $error("cramWrite or cksumError high during reset");
      failCount++;
    end

  // Consumer drains every cycle so the buffer never fills
  bufferNeverFull: assert property (@(posedge clk) disable iff (rst) bufCount < `FIFO_DEPTH)
    else begin
      $error("word buffer reached its depth");
      failCount++;
    end

endmodule

bind ramLoader ramLoaderAsserts checks (
  .clk (clk),
  .rst (rst),
  .cramWrite (cramWrite),
  .cksumError (cksumError),
  .formatError (formatError),
  .bufCount (wordBuffer.count)
);

//--- tb.f
+incdir+.
loadFilePkg.sv
cramPkg.sv
wordFifoIf.sv
asciiFieldDecoder.sv
wordFifo.sv
cramRecordAssembler.sv
ramLoader.sv
ramLoader_asserts.sv
tb.sv

//--- tb.sv
// Testbench for the KL10 CRAM loader, sends load file lines and checks CRAM writes
`include "ramLoad_macros.svh"

module tb import loadFilePkg::*, cramPkg::*; ();

  timeunit 1ns;
  timeprecision 100ps;

  localparam int timeoutCycles = 400;
  // Error pulses trail the newline strobe by three cycles
  localparam int settleCycles = 5;

  logic clk;
  logic rst;
  logic charStrobe;
  asciiChar_t charIn;
  logic cramWrite;
  cramAdr_t cramAdr;
  cramWord_t cramData;
  logic cksumError;
  logic formatError;

  // Expected writes, oldest first
  cramAdr_t expAdrQ[$];
  cramWord_t expWordQ[$];
  // Where a C line with zero ADR goes on
  cramAdr_t remAdr;
  int cksumCount = 0;
  int formatCount = 0;

  ramLoader i_dut (
    .clk (clk),
    .rst (rst),
    .charStrobe (charStrobe),
    .charIn (charIn),
    .cramWrite (cramWrite),
    .cramAdr (cramAdr),
    .cramData (cramData),
    .cksumError (cksumError),
    .formatError (formatError)
  );

  always #10 clk = ~clk;

  ////////////////////////////////////////////////////////////////////////////
  // Reference model
  ////////////////////////////////////////////////////////////////////////////

  // Six data words in file order to one CRAM word
  function automatic cramWord_t expectedCram(input loadWord_t w [`WORDS_PER_CRAM]);
    cramWord_t r;
    r = '0;
    r[64:79] = w[0];
    r[48:63] = w[1];
    r[32:47] = w[2];
    r[16:31] = w[3];
    r[0:15] = w[4];
    // Only the low six bits of the last word
    r[80:85] = w[5][5:0];
    return r;
  endfunction

  // Six bit group as a file character
  // 75 may go either way, 76 and 77 are sent as they are
  function automatic asciiChar_t asciize(input logic [5:0] g);
    asciiChar_t c;
    if (g == 6'o75 && $urandom_range(1, 0) == 0) c = 7'o075;
    else if (g >= 6'o76) c = {1'b0, g};
    else c = 7'o100 | {1'b0, g};
    return c;
  endfunction

  ////////////////////////////////////////////////////////////////////////////
  // Checks
  ////////////////////////////////////////////////////////////////////////////

  task automatic reportFail(input string msg);
    $display("%s", msg);
    $display("sim failed");
    $fatal(1);
  endtask

  task automatic checkCram(input cramAdr_t gotAdr, input cramWord_t gotWord,
                           input cramAdr_t expAdr, input cramWord_t expWord);
    if (gotAdr !== expAdr || gotWord !== expWord)
      reportFail($sformatf("MISMATCH at %0t: CRAM adr %o data %h, expected adr %o data %h",
                           $time, gotAdr, gotWord, expAdr, expWord));
  endtask

  task automatic checkFlag(input string name, input logic got, input logic exp);
    if (got !== exp)
      reportFail($sformatf("MISMATCH at %0t: %s pulse seen %b, expected %b",
                           $time, name, got, exp));
  endtask

  // Compare each write as it happens and count error pulses
  always @(posedge clk) begin
    if (!rst) begin
      if (cramWrite) begin
        if (expAdrQ.size() == 0)
          reportFail("cramWrite pulsed while no CRAM write was expected");
        else
          checkCram(cramAdr, cramData, expAdrQ.pop_front(), expWordQ.pop_front());
      end
      if (cksumError) cksumCount++;
      if (formatError) formatCount++;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Stimulus
  ////////////////////////////////////////////////////////////////////////////

  // Random idle gap, then one strobe
  task automatic sendChar(input asciiChar_t c);
    int gap;
    gap = $urandom_range(2, 0);
    repeat (gap) begin
      @(posedge clk);
      charStrobe <= 1'b0;
    end
    @(posedge clk);
    charStrobe <= 1'b1;
    charIn <= c;
  endtask

  // Three groups, MS first, top group holds bits 15..12
  task automatic sendWord(input loadWord_t w);
    logic [17:0] bits;
    bits = {2'b00, w};
    sendChar(asciize(bits[17:12]));
    sendChar(asciize(bits[11:6]));
    sendChar(asciize(bits[5:0]));
  endtask

  task automatic sendRecord(input asciiChar_t recType, input loadWord_t fields[$]);
    sendChar(recType);
    sendChar(7'o040);
    foreach (fields[i]) begin
      sendWord(fields[i]);
      sendChar(i == fields.size() - 1 ? `CH_NEWLINE : `CH_COMMA);
    end
    @(posedge clk);
    charStrobe <= 1'b0;
  endtask

  // Literal line text followed by a newline
  task automatic sendText(input string s);
    for (int i = 0; i < s.len(); i++) sendChar(asciiChar_t'(s[i]));
    sendChar(`CH_NEWLINE);
    @(posedge clk);
    charStrobe <= 1'b0;
  endtask

  task automatic finishLine(input int cksBefore, input int fmtBefore,
                            input logic expCks, input logic expFmt);
    int n;
    n = 0;
    while (expAdrQ.size() != 0 && n < timeoutCycles) begin
      @(posedge clk);
      n++;
    end
    if (expAdrQ.size() != 0)
      reportFail("Timed out waiting for the expected CRAM writes");
    repeat (settleCycles) @(posedge clk);
    if (cksumCount - cksBefore > 1 || formatCount - fmtBefore > 1)
      reportFail("An error output pulsed more than once for one line");
    checkFlag("cksumError", cksumCount != cksBefore, expCks);
    checkFlag("formatError", formatCount != fmtBefore, expFmt);
  endtask

  // C line, expected writes are queued before the first character
  task automatic runCLine(input loadWord_t adrWord, input loadWord_t data[$],
                          input logic corrupt);
    loadWord_t fields[$];
    loadWord_t slots [`WORDS_PER_CRAM];
    loadWord_t sum;
    loadWord_t chk;
    cramAdr_t adr;
    int cks;
    int fmt;
    fields.push_back(loadWord_t'(data.size()));
    fields.push_back(adrWord);
    adr = (adrWord != '0) ? adrWord[`CRAM_ADR_BITS-1:0] : remAdr;
    foreach (data[i]) begin
      fields.push_back(data[i]);
      slots[i % `WORDS_PER_CRAM] = data[i];
      if (i % `WORDS_PER_CRAM == `WORDS_PER_CRAM - 1) begin
        expAdrQ.push_back(adr);
        expWordQ.push_back(expectedCram(slots));
        adr = adr + 1'b1;
      end
    end
    remAdr = adr;
    sum = '0;
    foreach (fields[i]) sum = sum + fields[i];
    // Two's complement brings the line total to zero
    chk = ~sum + 1'b1;
    if (corrupt) chk = chk + 1'b1;
    fields.push_back(chk);
    cks = cksumCount;
    fmt = formatCount;
    sendRecord(7'h43, fields);
    finishLine(cks, fmt, corrupt, 1'b0);
  endtask

  task automatic runRandomCLine(input loadWord_t adrWord, input int nCram,
                                input logic corrupt);
    loadWord_t data[$];
    repeat (nCram * `WORDS_PER_CRAM) data.push_back(loadWord_t'($urandom));
    runCLine(adrWord, data, corrupt);
  endtask

  // Lines that never write
  task automatic runTextLine(input string s, input logic badType);
    int cks;
    int fmt;
    cks = cksumCount;
    fmt = formatCount;
    sendText(s);
    finishLine(cks, fmt, 1'b0, badType);
  endtask

  initial begin
    loadWord_t special [`WORDS_PER_CRAM];
    loadWord_t fixed[$];
    void'($urandom(47));
    clk = 1'b0;
    rst = 1'b1;
    charStrobe = 1'b0;
    charIn = '0;
    remAdr = '0;
    repeat (4) @(posedge clk);
    rst <= 1'b0;
    @(posedge clk);

    // Explicit address, then a line that goes on from it
    runRandomCLine(16'o1200, 3, 1'b0);
    runRandomCLine(16'o0, 2, 1'b0);

    // End marker, the next zero ADR line starts at 0
    runTextLine("C ,,", 1'b0);
    remAdr = '0;
    runRandomCLine(16'o0, 1, 1'b0);

    // Bad checksum still writes its words
    runRandomCLine(16'o0345, 2, 1'b1);
    runRandomCLine(16'o0, 1, 1'b0);

    runTextLine("D AB,CD,EF", 1'b0);
    runTextLine("Z AB,CD", 1'b0);
    runTextLine("; comment, with commas", 1'b0);
    runTextLine("Q AB,CD", 1'b1);

    // Groups 75, 76 and 77 in every position that can hold them
    special = '{16'o177777, 16'o007576, 16'o007577, 16'o017500, 16'o000075, 16'o000077};
    foreach (special[i]) fixed.push_back(special[i]);
    runCLine(16'o0, fixed, 1'b0);

    // Bound properties must not have failed anywhere in the run
    if (i_dut.checks.failCount != 0)
      reportFail("A bound assertion on the loader failed during the run");
    else begin
      $display("sim passed");
      $finish;
    end
  end

endmodule

//--- wordFifo.sv
// Small circular buffer carrying any payload from decoder to assembler
`include "ramLoad_macros.svh"

module wordFifo #(
  parameter type entryT = logic,
  parameter int depth = `FIFO_DEPTH
) (
  input logic clk,
  input logic rst,
  wordFifoIf.bufferIn wr,
  wordFifoIf.bufferOut rd
);

  localparam int ptrBits = (depth > 1) ? $clog2(depth) : 1;
  localparam int countBits = $clog2(depth + 1);

  entryT mem [depth];
  logic [ptrBits-1:0] wrPtr;
  logic [ptrBits-1:0] rdPtr;
  logic [countBits-1:0] count;
  logic doPop;

  // Wraps at depth so any depth works
  function automatic logic [ptrBits-1:0] nextPtr(input logic [ptrBits-1:0] p);
    return (p == ptrBits'(depth - 1)) ? '0 : p + 1'b1;
  endfunction

  // A pop on an empty buffer is ignored
  assign doPop = rd.pop && (count != '0);

  ////////////////////////////////////////////////////////////////////////////
  // Pointers and occupancy
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (rst) begin
      wrPtr <= '0;
      rdPtr <= '0;
      count <= '0;
    end else begin
      if (wr.push) wrPtr <= nextPtr(wrPtr);
      if (doPop) rdPtr <= nextPtr(rdPtr);
      case ({wr.push, doPop})
        2'b10: count <= count + 1'b1;
        2'b01: count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

  // Storage
  always_ff @(posedge clk) begin
    if (wr.push) mem[wrPtr] <= wr.pushEntry;
  end

  // Oldest entry always on view, so notEmpty trails a push by one cycle
  assign rd.popEntry = mem[rdPtr];
  assign rd.notEmpty = count != '0;

endmodule

//--- wordFifoIf.sv
// Push and pop signals of the word buffer, generic in the entry type
interface wordFifoIf #(
  parameter type entryT = logic
);

  // Writer side
  logic push;
  entryT pushEntry;

  // Reader side
  logic pop;
  entryT popEntry;
  logic notEmpty;

  ////////////////////////////////////////////////////////////////////////////
  // Views of the producer and consumer
  ////////////////////////////////////////////////////////////////////////////

  // Producer writes one entry per push
  modport writer (output push, output pushEntry);

  // Consumer takes popEntry while notEmpty and acks with pop
  modport reader (output pop, input popEntry, input notEmpty);

  ////////////////////////////////////////////////////////////////////////////
  // Views of the buffer itself
  ////////////////////////////////////////////////////////////////////////////

  // Buffer accepts what the writer drives
  modport bufferIn (input push, input pushEntry);

  // Buffer presents the oldest entry to the reader
  modport bufferOut (input pop, output popEntry, output notEmpty);

endinterface
